// File: compile.f
+incdir+include
source/dbg_pkg.sv
source/dm_control.sv
source/abstract_regs.sv
source/dbg_fsm.sv
source/dmi_read.sv
source/dbg_top.sv
test/core_model.sv
test/tb_dbg.sv

// File: include/dbg_cfg.svh
// debug module constants
// DMI register map, dmstatus version, abstract data count and command types

`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// ************************************************************
// DMI register addresses
// ************************************************************
`define DBG_ADDR_DATA0       7'h04
`define DBG_ADDR_DATA1       7'h05
`define DBG_ADDR_DMCONTROL   7'h10
`define DBG_ADDR_DMSTATUS    7'h11
`define DBG_ADDR_ABSTRACTCS  7'h16
`define DBG_ADDR_COMMAND     7'h17
`define DBG_ADDR_HALTSUM0    7'h40

// ************************************************************
// status fields and abstract command types
// ************************************************************
`define DBG_VERSION          4'd2    // debug spec 0.13
`define DBG_DATACOUNT        4'd2    // data0 and data1

`define DBG_CMDTYPE_REG      8'd0    // access register
`define DBG_CMDTYPE_MEM      8'd2    // access memory

`endif

// File: source/abstract_regs.sv
// abstract command registers
// command, abstractcs, data0 and data1, with cmderr detection and the
// command decode toward the core

`include "dbg_cfg.svh"

module abstract_regs import dbg_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  dmi_req_t    dmi,
   input  logic        dm_active,
   input  dbg_state_e  state,
   input  core_rsp_t   core_rsp,
   input  logic        dma_dbg_ready,
   input  logic        busy_set,
   input  logic        busy_clr,
   output logic        cmd_wr_ok,
   output cmderr_e     cmderr,
   output logic        busy,
   output logic [31:0] data0,
   output logic [31:0] data1,
   output command_u    command,
   output dbg_cmd_t    dbg_cmd,
   output logic        dbg_dma_bubble
);

   logic     dmi_wr;
   logic     cmd_wr;
   logic     acs_wr;
   logic     data0_wr;
   logic     data1_wr;
   logic     data0_rd_ld;
   logic     busy_access;
   command_u new_cmd;
   logic     new_cmd_legal;
   logic     new_cmd_bus_err;
   logic     mem_cmd;
   cmderr_e  cmderr_d;

   assign dmi_wr    = dmi.en & dmi.wr_en;
   assign cmd_wr    = dmi_wr & (dmi.addr == `DBG_ADDR_COMMAND);
   assign acs_wr    = dmi_wr & (dmi.addr == `DBG_ADDR_ABSTRACTCS);
   assign cmd_wr_ok = cmd_wr & (state == HALTED);

   assign data0_wr    = dmi_wr & (dmi.addr == `DBG_ADDR_DATA0) & (state == HALTED);
   assign data1_wr    = dmi_wr & (dmi.addr == `DBG_ADDR_DATA1) & (state == HALTED);
   assign data0_rd_ld = core_rsp.done & (state == CMD_WAIT) & ~command.reg_cmd.write;

   // ************************************************************
   // cmderr detection
   // ************************************************************
   assign new_cmd       = dmi.wdata;
   assign new_cmd_legal = (new_cmd.reg_cmd.cmdtype == `DBG_CMDTYPE_REG) |
                          (new_cmd.mem_cmd.cmdtype == `DBG_CMDTYPE_MEM);

   // misaligned data1, or a size other than byte, halfword or word
   assign new_cmd_bus_err = (new_cmd.mem_cmd.cmdtype == `DBG_CMDTYPE_MEM) &
                            (((new_cmd.mem_cmd.aamsize == 3'd1) & data1[0]) |
                             ((new_cmd.mem_cmd.aamsize == 3'd2) & (|data1[1:0])) |
                             (new_cmd.mem_cmd.aamsize > 3'd2));

   // touching command, abstractcs or data0 while a command runs
   assign busy_access = busy & dmi.en &
                        ((cmd_wr | acs_wr) | (dmi.addr == `DBG_ADDR_DATA0));

   always_comb begin
      if (busy_access) begin
         cmderr_d = BUSY;
      end else if (cmd_wr & ~new_cmd_legal) begin
         cmderr_d = NOT_SUPPORTED;
      end else if (core_rsp.done & core_rsp.fail) begin
         cmderr_d = EXCEPTION;
      end else if (cmd_wr & (state != HALTED)) begin
         cmderr_d = HALT_RESUME;
      end else if (cmd_wr & new_cmd_bus_err) begin
         cmderr_d = BUS;
      end else if (acs_wr) begin
         cmderr_d = cmderr_e'(cmderr & ~dmi.wdata[10:8]);  // write one to clear
      end else begin
         cmderr_d = cmderr;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy   <= 1'b0;
         cmderr <= NONE;
      end else if (!dm_active) begin
         busy   <= 1'b0;
         cmderr <= NONE;
      end else begin
         if (busy_set) begin
            busy <= 1'b1;
         end else if (busy_clr) begin
            busy <= 1'b0;
         end
         cmderr <= cmderr_d;
      end
   end

   // command and data words
   always_ff @(posedge clk) begin
      if (!dm_active) begin
         command <= '0;
         data0   <= '0;
         data1   <= '0;
      end else begin
         if (cmd_wr_ok) begin
            command <= new_cmd;
         end
         if (data0_wr) begin
            data0 <= dmi.wdata;
         end else if (data0_rd_ld) begin
            data0 <= core_rsp.rddata;            // register or memory read result
         end
         if (data1_wr) begin
            data1 <= dmi.wdata;
         end
      end
   end

   // ************************************************************
   // command toward the core
   // ************************************************************
   assign mem_cmd = (command.mem_cmd.cmdtype == `DBG_CMDTYPE_MEM);

   assign dbg_cmd.valid    = (state == CMD_START) & (cmderr == NONE) & dma_dbg_ready;
   assign dbg_cmd.write    = command.reg_cmd.write;
   assign dbg_cmd.cmd_type = mem_cmd ? 2'd2 : {1'b0, (command.reg_cmd.regno[15:12] == 4'h0)};
   assign dbg_cmd.size     = command.mem_cmd.aamsize[1:0];
   assign dbg_cmd.addr     = mem_cmd ? {data1[31:2], 2'b00} :   // word aligned memory address
                                       {20'h0, command.reg_cmd.regno[11:0]};
   assign dbg_cmd.wrdata   = data0;

   // keep DMA off the bus from command start until the core answers
   assign dbg_dma_bubble = ((state == CMD_START) & (cmderr == NONE)) | (state == CMD_WAIT);

endmodule

// File: source/dbg_fsm.sv
// debug state machine
// runs the halt, abstract command and resume sequence and
// generates the halt and resume requests to the core

module dbg_fsm import dbg_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         dm_active,
   input  dmcontrol_t   ctrl,
   input  logic         ctrl_wr_q,
   input  logic         halted,
   input  logic         resume_ack,
   input  core_status_t core_status,
   input  logic         cmd_wr_ok,
   input  cmderr_e      cmderr,
   input  logic         dbg_cmd_valid,
   input  logic         core_done,
   output dbg_state_e   state,
   output logic         busy_set,
   output logic         busy_clr,
   output logic         dbg_halt_req,
   output logic         dbg_resume_req
);

   dbg_state_e next_state;
   logic       state_en;
   logic       halt_seen;    // halted by the debugger or by MPC
   logic       resume_wr;

   assign halt_seen = halted | core_status.mpc_halted_only;
   assign resume_wr = ctrl_wr_q & ctrl.resumereq & ~ctrl.haltreq;

   always_comb begin
      next_state     = IDLE;
      state_en       = 1'b0;
      busy_set       = 1'b0;
      busy_clr       = 1'b0;
      dbg_halt_req   = ctrl_wr_q & ctrl.haltreq;    // pulse after a haltreq write
      dbg_resume_req = 1'b0;
      case (state)
         IDLE: begin
            next_state   = halt_seen ? HALTED : HALTING;
            state_en     = ((ctrl.haltreq & ~core_status.debug_mode) | halt_seen) &
                           ~ctrl.ndmreset;
            dbg_halt_req = ctrl.haltreq;             // level while idle
         end
         HALTING: begin
            next_state = HALTED;
            state_en   = halted;
         end
         HALTED: begin
            if (ctrl.ndmreset | ~halt_seen) begin
               // core being reset or no longer halted
               next_state = ctrl.haltreq ? HALTING : IDLE;
               state_en   = 1'b1;
            end else if (halted & cmd_wr_ok) begin
               next_state = CMD_START;
               state_en   = 1'b1;
               busy_set   = 1'b1;
            end else if (halted & resume_wr) begin
               next_state     = RESUMING;
               state_en       = 1'b1;
               dbg_resume_req = 1'b1;
            end
         end
         CMD_START: begin
            next_state = (cmderr != NONE) ? CMD_DONE : CMD_WAIT;
            state_en   = dbg_cmd_valid | (cmderr != NONE);   // waits on dma_dbg_ready
         end
         CMD_WAIT: begin
            next_state = CMD_DONE;
            state_en   = core_done;
         end
         CMD_DONE: begin
            next_state = HALTED;
            state_en   = 1'b1;
            busy_clr   = 1'b1;
         end
         RESUMING: begin
            next_state = IDLE;
            state_en   = resume_ack;                 // dmstatus resumeack now set
         end
         default: begin
            next_state = IDLE;
            state_en   = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= IDLE;
      end else if (!dm_active) begin
         state <= IDLE;
      end else if (state_en) begin
         state <= next_state;
      end
   end

endmodule

// File: source/dbg_pkg.sv
// debug module types
// DMI request, dmcontrol bits, core interface and the two views of the command word

package dbg_pkg;

   // one DMI access from the JTAG side
   typedef struct packed {
      logic        en;       // access strobe, read or write
      logic        wr_en;
      logic [6:0]  addr;
      logic [31:0] wdata;
   } dmi_req_t;

   // implemented dmcontrol bits, in register order
   typedef struct packed {
      logic haltreq;         // bit 31
      logic resumereq;       // bit 30
      logic haltreset;       // bit 29
      logic ackhavereset;    // bit 28
      logic ndmreset;        // bit 1
      logic dmactive;        // bit 0
   } dmcontrol_t;

   typedef struct packed {
      logic debug_mode;
      logic halted;
      logic mpc_halted_only; // halted by MPC, not by the debugger
      logic resume_ack;      // single cycle
   } core_status_t;

   typedef struct packed {
      logic        valid;
      logic        write;
      logic [1:0]  cmd_type; // 0 gpr, 1 csr, 2 memory
      logic [1:0]  size;
      logic [31:0] addr;
      logic [31:0] wrdata;
   } dbg_cmd_t;

   typedef struct packed {
      logic        done;
      logic        fail;     // exception while running the command
      logic [31:0] rddata;
   } core_rsp_t;

   // ************************************************************
   // command register layouts
   // ************************************************************
   typedef struct packed {
      logic [7:0]  cmdtype;
      logic        rsvd;
      logic [2:0]  size;
      logic        postincrement;
      logic        postexec;
      logic        transfer;
      logic        write;
      logic [15:0] regno;
   } access_reg_t;

   typedef struct packed {
      logic [7:0]  cmdtype;
      logic        aamvirtual;
      logic [2:0]  aamsize;
      logic        aampostincrement;
      logic [1:0]  rsvd0;
      logic        write;
      logic [1:0]  target_specific;
      logic [13:0] rsvd1;
   } access_mem_t;

   typedef union packed {
      access_reg_t reg_cmd;
      access_mem_t mem_cmd;
   } command_u;

   typedef enum logic [2:0] {
      NONE          = 3'd0,
      BUSY          = 3'd1,
      NOT_SUPPORTED = 3'd2,
      EXCEPTION     = 3'd3,
      HALT_RESUME   = 3'd4,
      BUS           = 3'd7
   } cmderr_e;

   typedef enum logic [2:0] {
      IDLE      = 3'd0,
      HALTING   = 3'd1,
      HALTED    = 3'd2,
      CMD_START = 3'd3,
      CMD_WAIT  = 3'd4,
      CMD_DONE  = 3'd5,
      RESUMING  = 3'd6
   } dbg_state_e;

endpackage

// File: source/dbg_top.sv
// debug module top
// bridges DMI register accesses to the core's halt, resume and abstract command ports

module dbg_top import dbg_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,
   input  dmi_req_t     dmi,
   input  core_status_t core_status,
   input  core_rsp_t    core_rsp,
   input  logic         dma_dbg_ready,
   output logic [31:0]  dmi_reg_rdata,
   output dbg_cmd_t     dbg_cmd,
   output logic         dbg_halt_req,
   output logic         dbg_resume_req,
   output logic         dbg_dma_bubble,
   output logic         dbg_core_rst_n
);

   dmcontrol_t  ctrl;
   logic        ctrl_wr_q;
   logic        dm_active;
   logic        halted;
   logic        resume_ack;
   logic        havereset;
   logic        cmd_wr_ok;
   cmderr_e     cmderr;
   logic        busy;
   logic [31:0] data0;
   logic [31:0] data1;
   command_u    command;
   dbg_state_e  state;
   logic        busy_set;
   logic        busy_clr;

   dm_control i_dm_control (
      .clk            (clk),
      .arst_n         (arst_n),
      .dmi            (dmi),
      .core_status    (core_status),
      .state          (state),
      .ctrl           (ctrl),
      .ctrl_wr_q      (ctrl_wr_q),
      .dm_active      (dm_active),
      .halted         (halted),
      .resume_ack     (resume_ack),
      .havereset      (havereset),
      .dbg_core_rst_n (dbg_core_rst_n)
   );

   abstract_regs i_abstract_regs (
      .clk            (clk),
      .arst_n         (arst_n),
      .dmi            (dmi),
      .dm_active      (dm_active),
      .state          (state),
      .core_rsp       (core_rsp),
      .dma_dbg_ready  (dma_dbg_ready),
      .busy_set       (busy_set),
      .busy_clr       (busy_clr),
      .cmd_wr_ok      (cmd_wr_ok),
      .cmderr         (cmderr),
      .busy           (busy),
      .data0          (data0),
      .data1          (data1),
      .command        (command),
      .dbg_cmd        (dbg_cmd),
      .dbg_dma_bubble (dbg_dma_bubble)
   );

   dbg_fsm i_dbg_fsm (
      .clk            (clk),
      .arst_n         (arst_n),
      .dm_active      (dm_active),
      .ctrl           (ctrl),
      .ctrl_wr_q      (ctrl_wr_q),
      .halted         (halted),
      .resume_ack     (resume_ack),
      .core_status    (core_status),
      .cmd_wr_ok      (cmd_wr_ok),
      .cmderr         (cmderr),
      .dbg_cmd_valid  (dbg_cmd.valid),
      .core_done      (core_rsp.done),
      .state          (state),
      .busy_set       (busy_set),
      .busy_clr       (busy_clr),
      .dbg_halt_req   (dbg_halt_req),
      .dbg_resume_req (dbg_resume_req)
   );

   dmi_read i_dmi_read (
      .clk            (clk),
      .arst_n         (arst_n),
      .dmi            (dmi),
      .ctrl           (ctrl),
      .halted         (halted),
      .resume_ack     (resume_ack),
      .havereset      (havereset),
      .cmderr         (cmderr),
      .busy           (busy),
      .command        (command),
      .data0          (data0),
      .data1          (data1),
      .dmi_reg_rdata  (dmi_reg_rdata)
   );

endmodule

// File: source/dm_control.sv
// debug module control and status
// holds dmcontrol, the registered halted and resumeack status and havereset,
// and drives the non-debug-module reset to the core

`include "dbg_cfg.svh"

module dm_control import dbg_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,
   input  dmi_req_t     dmi,
   input  core_status_t core_status,
   input  dbg_state_e   state,
   output dmcontrol_t   ctrl,
   output logic         ctrl_wr_q,
   output logic         dm_active,
   output logic         halted,
   output logic         resume_ack,
   output logic         havereset,
   output logic         dbg_core_rst_n
);

   logic       ctrl_wr;
   dmcontrol_t wr_val;
   logic       resume_ack_set;

   assign ctrl_wr = dmi.en & dmi.wr_en & (dmi.addr == `DBG_ADDR_DMCONTROL);

   // only six bits of dmcontrol are implemented
   assign wr_val = {dmi.wdata[31:28], dmi.wdata[1:0]};

   assign resume_ack_set = (state == RESUMING) & core_status.resume_ack;

   // ************************************************************
   // dmcontrol and status registers
   // ************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ctrl       <= '0;
         ctrl_wr_q  <= 1'b0;
         halted     <= 1'b0;
         resume_ack <= 1'b0;
         havereset  <= 1'b0;
      end else begin
         if (ctrl_wr) begin
            ctrl.dmactive <= wr_val.dmactive;  // only power-on reset clears it
         end
         if (!dm_active) begin
            ctrl[5:1]  <= '0;                  // debug module held in reset
            ctrl_wr_q  <= 1'b0;
            halted     <= 1'b0;
            resume_ack <= 1'b0;
            havereset  <= 1'b0;
         end else begin
            if (ctrl_wr) begin
               ctrl[5:1] <= wr_val[5:1];
            end
            ctrl_wr_q <= ctrl_wr;
            halted    <= core_status.halted & ~core_status.mpc_halted_only;

            // resumeack holds until the debugger drops resumereq
            if (resume_ack_set) begin
               resume_ack <= 1'b1;
            end else if (!ctrl.resumereq) begin
               resume_ack <= 1'b0;
            end

            if (ctrl_wr & wr_val.ackhavereset) begin
               havereset <= 1'b0;
            end else if (ctrl_wr & wr_val.ndmreset) begin
               havereset <= 1'b1;
            end
         end
      end
   end

   assign dm_active      = ctrl.dmactive;
   assign dbg_core_rst_n = ~ctrl.ndmreset;

endmodule

// File: source/dmi_read.sv
// DMI read path
// builds dmcontrol, dmstatus, abstractcs and haltsum0 images,
// selects one by address and registers it on each access

`include "dbg_cfg.svh"

module dmi_read import dbg_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   input  dmi_req_t    dmi,
   input  dmcontrol_t  ctrl,
   input  logic        halted,
   input  logic        resume_ack,
   input  logic        havereset,
   input  cmderr_e     cmderr,
   input  logic        busy,
   input  command_u    command,
   input  logic [31:0] data0,
   input  logic [31:0] data1,
   output logic [31:0] dmi_reg_rdata
);

   logic [31:0] dmcontrol_w;
   logic [31:0] dmstatus_w;
   logic [31:0] abstractcs_w;
   logic [31:0] haltsum0_w;
   logic [31:0] rdata_d;

   assign dmcontrol_w = {ctrl.haltreq, ctrl.resumereq, ctrl.haltreset, ctrl.ackhavereset,
                         26'h0, ctrl.ndmreset, ctrl.dmactive};

   // all* and any* pairs read the same bit, there is one hart
   assign dmstatus_w = {12'h0, {2{havereset}}, {2{resume_ack}}, 6'h0, {2{halted}},
                        1'b1, 3'h0, `DBG_VERSION};           // bit 7 authenticated

   assign abstractcs_w = {19'h0, busy, 1'b0, cmderr, 4'h0, `DBG_DATACOUNT};
   assign haltsum0_w   = {31'h0, halted};

   always_comb begin
      case (dmi.addr)
         `DBG_ADDR_DATA0:      rdata_d = data0;
         `DBG_ADDR_DATA1:      rdata_d = data1;
         `DBG_ADDR_DMCONTROL:  rdata_d = dmcontrol_w;
         `DBG_ADDR_DMSTATUS:   rdata_d = dmstatus_w;
         `DBG_ADDR_ABSTRACTCS: rdata_d = abstractcs_w;
         `DBG_ADDR_COMMAND:    rdata_d = command;
         `DBG_ADDR_HALTSUM0:   rdata_d = haltsum0_w;
         default:              rdata_d = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dmi_reg_rdata <= '0;
      end else if (dmi.en) begin
         dmi_reg_rdata <= rdata_d;    // held between accesses
      end
   end

endmodule

// File: test/core_model.sv
// behavioral core for the debug module testbench
// answers halt and resume requests and runs abstract commands with a fixed latency

module core_model import dbg_pkg::*; (
   input  logic         clk,
   input  logic         arst_n,
   input  logic         dbg_halt_req,
   input  logic         dbg_resume_req,
   input  dbg_cmd_t     dbg_cmd,
   input  logic         dbg_dma_bubble,
   output core_status_t core_status,
   output core_rsp_t    core_rsp,
   output logic         dma_dbg_ready,
   output dbg_cmd_t     last_cmd
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [31:0] RD_XOR    = 32'hA5A5_0000;   // read data = address ^ this
   localparam logic [31:0] FAIL_ADDR = 32'h0000_DEAD;

   core_status_t status_q;
   core_rsp_t    rsp_q;
   logic         ready_q;
   logic [1:0]   halt_cnt;
   logic [2:0]   done_cnt;
   logic [1:0]   start_cnt;   // bubble cycles seen at command start

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         status_q  <= '0;
         rsp_q     <= '0;
         ready_q   <= 1'b0;
         halt_cnt  <= '0;
         done_cnt  <= '0;
         start_cnt <= '0;
         last_cmd  <= '0;
      end else begin
         // ************************************************************
         // halt and resume
         // ************************************************************
         status_q.resume_ack <= 1'b0;
         if (dbg_resume_req && status_q.halted) begin
            status_q.halted     <= 1'b0;
            status_q.debug_mode <= 1'b0;
            status_q.resume_ack <= 1'b1;   // single cycle
         end else if (halt_cnt != 2'd0) begin
            halt_cnt <= halt_cnt - 2'd1;
            if (halt_cnt == 2'd1) begin
               status_q.halted     <= 1'b1;
               status_q.debug_mode <= 1'b1;
            end
         end else if (dbg_halt_req && !status_q.halted) begin
            halt_cnt <= 2'd3;
         end

         // DMA keeps the bus for the first two cycles of a command
         if (!dbg_dma_bubble) begin
            start_cnt <= '0;
            ready_q   <= 1'b0;
         end else if (start_cnt < 2'd2) begin
            start_cnt <= start_cnt + 2'd1;
            ready_q   <= (start_cnt == 2'd1);
         end

         // ************************************************************
         // abstract command execution
         // ************************************************************
         rsp_q.done <= 1'b0;
         rsp_q.fail <= 1'b0;
         if (dbg_cmd.valid) begin
            last_cmd <= dbg_cmd;
            done_cnt <= 3'd4;
         end else if (done_cnt != 3'd0) begin
            done_cnt <= done_cnt - 3'd1;
            if (done_cnt == 3'd1) begin
               rsp_q.done   <= 1'b1;
               // any access to the word holding the faulting byte
               rsp_q.fail   <= ({last_cmd.addr[31:2], 2'b00} == {FAIL_ADDR[31:2], 2'b00});
               rsp_q.rddata <= last_cmd.addr ^ RD_XOR;
            end
         end
      end
   end

   assign core_status   = arst_n ? status_q : '0;
   assign core_rsp      = arst_n ? rsp_q : '0;
   assign dma_dbg_ready = arst_n & ready_q;

endmodule

// File: test/tb_dbg.sv
// debug module testbench
// drives DMI accesses into the debug module and checks registers and core requests
// against a behavioral core

`include "dbg_cfg.svh"

module tb_dbg import dbg_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          TIMEOUT_CYCLES = 3000;  // six tests of up to ~400 cycles each
   localparam int          POLL_LIMIT     = 40;    // status reads before giving up
   localparam logic [31:0] RD_XOR         = 32'hA5A5_0000;

   logic         clk = 1'b0;
   logic         arst_n;
   dmi_req_t     dmi;
   core_status_t core_status;
   core_rsp_t    core_rsp;
   logic         dma_dbg_ready;
   logic [31:0]  dmi_reg_rdata;
   dbg_cmd_t     dbg_cmd;
   logic         dbg_halt_req;
   logic         dbg_resume_req;
   logic         dbg_dma_bubble;
   logic         dbg_core_rst_n;
   dbg_cmd_t     last_cmd;

   logic [31:0]  rng;
   int           cycles = 0;
   int           resume_pulses = 0;
   bit           bubble_seen = 1'b0;

   always #4 clk = ~clk;

   dbg_top i_dbg_top (
      .clk            (clk),
      .arst_n         (arst_n),
      .dmi            (dmi),
      .core_status    (core_status),
      .core_rsp       (core_rsp),
      .dma_dbg_ready  (dma_dbg_ready),
      .dmi_reg_rdata  (dmi_reg_rdata),
      .dbg_cmd        (dbg_cmd),
      .dbg_halt_req   (dbg_halt_req),
      .dbg_resume_req (dbg_resume_req),
      .dbg_dma_bubble (dbg_dma_bubble),
      .dbg_core_rst_n (dbg_core_rst_n)
   );

   core_model i_core_model (
      .clk            (clk),
      .arst_n         (arst_n),
      .dbg_halt_req   (dbg_halt_req),
      .dbg_resume_req (dbg_resume_req),
      .dbg_cmd        (dbg_cmd),
      .dbg_dma_bubble (dbg_dma_bubble),
      .core_status    (core_status),
      .core_rsp       (core_rsp),
      .dma_dbg_ready  (dma_dbg_ready),
      .last_cmd       (last_cmd)
   );

   // ************************************************************
   // monitors and run limit
   // ************************************************************
   always @(negedge clk) begin
      if (dbg_resume_req) resume_pulses++;
      if (dbg_dma_bubble) bubble_seen = 1'b1;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("STATUS: FAIL");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("** Error at %0t: %s expected 0x%08h, got 0x%08h",
                  $time, name, expected, actual);
         $display("STATUS: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run aborted");
   endtask

   task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
      @(posedge clk);
      dmi <= {1'b1, 1'b1, addr, data};
      @(posedge clk);
      dmi <= '0;
   endtask

   // rdata is registered on the access edge and sampled half a cycle later
   task automatic dmi_read(input logic [6:0] addr, output logic [31:0] data);
      @(posedge clk);
      dmi <= {1'b1, 1'b0, addr, 32'h0};
      @(posedge clk);
      dmi <= '0;
      @(negedge clk);
      data = dmi_reg_rdata;
   endtask

   task automatic wait_for_bit(input logic [6:0] addr, input int bit_idx,
                               input logic value, input string what);
      logic [31:0] rd;
      int          polls;
      polls = 0;
      dmi_read(addr, rd);
      while (rd[bit_idx] !== value) begin
         polls++;
         if (polls >= POLL_LIMIT) begin
            abort_run({"gave up waiting for ", what});
         end else begin
            dmi_read(addr, rd);
         end
      end
   endtask

   task automatic halt_core();
      dmi_write(`DBG_ADDR_DMCONTROL, 32'h8000_0001);   // haltreq, dmactive
      wait_for_bit(`DBG_ADDR_DMSTATUS, 9, 1'b1, "allhalted");
   endtask

   task automatic resume_core();
      dmi_write(`DBG_ADDR_DMCONTROL, 32'h4000_0001);   // resumereq, dmactive
      wait_for_bit(`DBG_ADDR_DMSTATUS, 17, 1'b1, "allresumeack");
   endtask

   task automatic wait_not_busy();
      wait_for_bit(`DBG_ADDR_ABSTRACTCS, 12, 1'b0, "abstractcs busy to clear");
   endtask

   task automatic expect_cmderr(input logic [2:0] value);
      logic [31:0] rd;
      dmi_read(`DBG_ADDR_ABSTRACTCS, rd);
      check("abstractcs.cmderr", value, rd[10:8]);
   endtask

   task automatic clear_cmderr();
      dmi_write(`DBG_ADDR_ABSTRACTCS, 32'h0000_0700);  // ones to cmderr
      expect_cmderr(3'd0);
   endtask

   // ************************************************************
   // directed tests
   // ************************************************************
   task automatic reset_values();
      logic [31:0] rd;
      @(negedge clk);
      check("dbg_halt_req", 32'd0, dbg_halt_req);
      check("dbg_resume_req", 32'd0, dbg_resume_req);
      check("dbg_cmd.valid", 32'd0, dbg_cmd.valid);
      check("dbg_dma_bubble", 32'd0, dbg_dma_bubble);
      check("dbg_core_rst_n", 32'd1, dbg_core_rst_n);
      dmi_read(`DBG_ADDR_DMSTATUS, rd);
      check("dmstatus", 32'h0000_0082, rd);            // authenticated, version 2
      dmi_read(`DBG_ADDR_DMCONTROL, rd);
      check("dmcontrol", 32'd0, rd);
      dmi_read(`DBG_ADDR_ABSTRACTCS, rd);
      check("abstractcs.busy", 32'd0, rd[12]);
      check("abstractcs.cmderr", 32'd0, rd[10:8]);
      dmi_read(`DBG_ADDR_HALTSUM0, rd);
      check("haltsum0", 32'd0, rd);
      dmi_write(`DBG_ADDR_DMCONTROL, 32'h0000_0001);   // bring the debug module up
   endtask

   task automatic halt_and_resume();
      logic [31:0] rd;
      int          pulses;
      halt_core();
      dmi_read(`DBG_ADDR_DMSTATUS, rd);
      check("dmstatus.allhalted/anyhalted", 32'd3, rd[9:8]);
      dmi_read(`DBG_ADDR_HALTSUM0, rd);
      check("haltsum0", 32'd1, rd);
      pulses = resume_pulses;
      resume_core();
      repeat (4) @(posedge clk);
      check("dbg_resume_req pulses", 32'd1, resume_pulses - pulses);
      dmi_read(`DBG_ADDR_DMSTATUS, rd);
      check("dmstatus.resumeack", 32'd3, rd[17:16]);
      check("dmstatus.halted", 32'd0, rd[9:8]);
   endtask

   task automatic register_read();
      logic [31:0] rd;
      logic [31:0] addr;
      halt_core();
      rng  = xorshift(rng);
      addr = {27'h0, rng[4:0]};                        // gpr number
      dmi_write(`DBG_ADDR_COMMAND, 32'h0022_1000 | addr);   // word, transfer, read
      wait_not_busy();
      check("dbg_cmd.addr", addr, last_cmd.addr);
      check("dbg_cmd.cmd_type", 32'd0, last_cmd.cmd_type);  // gpr
      check("dbg_cmd.write", 32'd0, last_cmd.write);
      dmi_read(`DBG_ADDR_DATA0, rd);
      check("data0", addr ^ RD_XOR, rd);
      dmi_read(`DBG_ADDR_ABSTRACTCS, rd);
      check("abstractcs.cmderr", 32'd0, rd[10:8]);
   endtask

   task automatic memory_write();
      logic [31:0] addr;
      logic [31:0] data;
      halt_core();
      rng  = xorshift(rng);
      addr = {rng[31:2], 2'b00} | 32'h0010_0000;       // keeps clear of the faulting word
      rng  = xorshift(rng);
      data = rng;
      dmi_write(`DBG_ADDR_DATA0, data);
      dmi_write(`DBG_ADDR_DATA1, addr);
      bubble_seen = 1'b0;
      dmi_write(`DBG_ADDR_COMMAND, 32'h0221_0000);     // access memory, word, write
      wait_not_busy();
      check("dbg_cmd.addr", addr, last_cmd.addr);
      check("dbg_cmd.wrdata", data, last_cmd.wrdata);
      check("dbg_cmd.cmd_type", 32'd2, last_cmd.cmd_type);
      check("dbg_cmd.write", 32'd1, last_cmd.write);
      check("dbg_cmd.size", 32'd2, last_cmd.size);
      check("dbg_dma_bubble seen", 32'd1, bubble_seen);
   endtask

   task automatic error_codes();
      halt_core();
      dmi_write(`DBG_ADDR_COMMAND, 32'h0100_0000);     // quick access
      wait_not_busy();
      expect_cmderr(3'd2);
      clear_cmderr();

      dmi_write(`DBG_ADDR_DATA1, 32'h0000_DEAD);
      dmi_write(`DBG_ADDR_COMMAND, 32'h0200_0000);     // byte read that the core faults on
      wait_not_busy();
      expect_cmderr(3'd3);
      clear_cmderr();

      dmi_write(`DBG_ADDR_DATA1, 32'h0000_1002);
      dmi_write(`DBG_ADDR_COMMAND, 32'h0220_0000);     // misaligned word read
      wait_not_busy();
      expect_cmderr(3'd7);
      clear_cmderr();

      resume_core();
      dmi_write(`DBG_ADDR_COMMAND, 32'h0022_1000);     // legal command while the core runs
      expect_cmderr(3'd4);
      clear_cmderr();
   endtask

   task automatic ndm_reset();
      logic [31:0] rd;
      dmi_write(`DBG_ADDR_DMCONTROL, 32'h0000_0003);   // ndmreset, dmactive
      @(negedge clk);
      check("dbg_core_rst_n", 32'd0, dbg_core_rst_n);
      dmi_read(`DBG_ADDR_DMSTATUS, rd);
      check("dmstatus.havereset", 32'd3, rd[19:18]);
      dmi_write(`DBG_ADDR_DMCONTROL, 32'h1000_0001);   // ackhavereset and release the core
      dmi_read(`DBG_ADDR_DMSTATUS, rd);
      check("dmstatus.havereset", 32'd0, rd[19:18]);
      check("dbg_core_rst_n", 32'd1, dbg_core_rst_n);
      dmi_write(`DBG_ADDR_DMCONTROL, 32'h2000_0000);   // dmactive low
      dmi_read(`DBG_ADDR_DMCONTROL, rd);
      check("dmcontrol", 32'd0, rd);
   endtask

   initial begin
      arst_n = 1'b0;
      dmi    = '0;
      rng    = 32'd97167;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      reset_values();
      halt_and_resume();
      register_read();
      memory_write();
      error_codes();
      ndm_reset();

      $display("STATUS: PASS");
      $finish;
   end

endmodule
